// ==== src/trap_defines.svh ====
//////////////////////////////
// Trap unit build parameters
// Widths, interrupt line count and trap queue depth
//////////////////////////////

`ifndef TRAP_DEFINES_SVH
`define TRAP_DEFINES_SVH

// Data and program counter width
`define TRAP_XLEN 32

// Number of machine interrupt lines seen by the trap unit
`define TRAP_NUM_IRQ 16

// Pending trap records held while a handler runs
`define TRAP_QUEUE_DEPTH 2

`endif

// ==== src/trap_cause_pkg.sv ====
//////////////////////////////
// Trap cause definitions
// Cause codes, mcause layout and the program counter type
//////////////////////////////

`default_nettype none

`include "trap_defines.svh"

package trap_cause_pkg;

  // Program counter as seen at retire and stored in mepc
  typedef logic [`TRAP_XLEN-1:0] addr_t;

  // Exception or interrupt code, as held in the low bits of mcause
  typedef logic [4:0] cause_code_t;

  // Full mcause register value
  typedef logic [`TRAP_XLEN-1:0] mcause_t;

  // Position of the interrupt flag inside mcause
  localparam int unsigned MCAUSE_IRQ_BIT = `TRAP_XLEN - 1;

  //////////////////////////////
  // Synchronous exception codes
  //////////////////////////////
  localparam cause_code_t CAUSE_INSTR_BUS_FAULT = 5'd1;
  localparam cause_code_t CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam cause_code_t CAUSE_BREAKPOINT      = 5'd3;
  localparam cause_code_t CAUSE_ECALL_MMODE     = 5'd11;

endpackage

`default_nettype wire

// ==== src/trap_state_pkg.sv ====
//////////////////////////////
// Trap unit state definitions
// Handler state machine encoding and interrupt mask type
//////////////////////////////

`default_nettype none

`include "trap_defines.svh"

package trap_state_pkg;

  // One bit per interrupt line, used for pending and enable masks
  typedef logic [`TRAP_NUM_IRQ-1:0] irq_mask_t;

  // The unit is either running normal code or inside a trap handler
  // Nested traps are not supported, so two states are enough
  typedef enum logic {
    RUN     = 1'b0,
    HANDLER = 1'b1
  } handler_state_e;

endpackage

`default_nettype wire

// ==== src/retire_exc_sel.sv ====
//////////////////////////////
// Retire exception selector
// Reduces the fault flags of a retired instruction to one registered trap record
//////////////////////////////

`default_nettype none

module retire_exc_sel
  import trap_cause_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_ni,
  input  wire logic        retire_valid_i,
  input  wire addr_t       retire_pc_i,
  input  wire logic        retire_bus_err_i,
  input  wire logic        retire_illegal_i,
  input  wire logic        retire_ecall_i,
  input  wire logic        retire_ebreak_i,
  output logic             exc_push_o,
  output addr_t            exc_pc_o,
  output cause_code_t      exc_code_o
);

  logic        any_flag;
  logic        sel_valid;
  cause_code_t sel_code;

  assign any_flag  = retire_bus_err_i | retire_illegal_i | retire_ecall_i | retire_ebreak_i;
  assign sel_valid = retire_valid_i & any_flag;

  // Fixed priority, the fetch side fault wins over any decode result
  always_comb begin
    if (retire_bus_err_i) begin
      sel_code = CAUSE_INSTR_BUS_FAULT;
    end else if (retire_illegal_i) begin
      sel_code = CAUSE_ILLEGAL_INSN;
    end else if (retire_ecall_i) begin
      sel_code = CAUSE_ECALL_MMODE;
    end else begin
      sel_code = CAUSE_BREAKPOINT;
    end
  end

  // Push strobe is the only control state here
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_push_o <= 1'b0;
    end else begin
      exc_push_o <= sel_valid;
    end
  end

  // Record fields are only meaningful while the push strobe is high
  always_ff @(posedge clk) begin
    if (sel_valid) begin
      exc_pc_o   <= retire_pc_i;
      exc_code_o <= sel_code;
    end
  end

  // A push must always trace back to a flagged retire one cycle earlier
  a_push_needs_flag : assert property (@(posedge clk) disable iff (!rst_ni)
    exc_push_o |-> $past(retire_valid_i && any_flag))
    else $error("retire_exc_sel: push without a flagged retire");

endmodule

`default_nettype wire

// ==== src/trap_queue.sv ====
//////////////////////////////
// Trap record queue
// In-order circular buffer of pending traps; full level stalls retire
//////////////////////////////

`default_nettype none

`include "trap_defines.svh"

module trap_queue
  import trap_cause_pkg::*;
#(
  parameter int unsigned DEPTH = `TRAP_QUEUE_DEPTH
) (
  input  wire logic        clk,
  input  wire logic        rst_ni,
  input  wire logic        push_i,
  input  wire addr_t       push_pc_i,
  input  wire cause_code_t push_code_i,
  input  wire logic        pop_i,
  output logic             valid_o,
  output addr_t            head_pc_o,
  output cause_code_t      head_code_o,
  output logic             full_o
);

  // A depth of one still needs a one bit pointer
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  addr_t       pc_mem   [DEPTH];
  cause_code_t code_mem [DEPTH];

  ptr_t rd_ptr_q;
  ptr_t wr_ptr_q;
  cnt_t count_q;
  logic push_ok;
  logic pop_ok;

  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == cnt_t'(DEPTH));

  // A pop frees a slot in the same edge, so push and pop may meet when full
  assign pop_ok  = pop_i & valid_o;
  assign push_ok = push_i & (~full_o | pop_ok);

  assign head_pc_o   = pc_mem[rd_ptr_q];
  assign head_code_o = code_mem[rd_ptr_q];

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Net change is zero when both sides fire together
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      pc_mem[wr_ptr_q]   <= push_pc_i;
      code_mem[wr_ptr_q] <= push_code_i;
    end
  end

  // Retire must have stalled before the last slot was taken
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_ni)
    push_i && full_o |-> pop_i)
    else $error("trap_queue: push into a full queue was dropped");

  // The CSR unit only pops when it sees a valid head
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_ni)
    pop_i |-> valid_o)
    else $error("trap_queue: pop from an empty queue");

endmodule

`default_nettype wire

// ==== src/trap_csr_unit.sv ====
//////////////////////////////
// Machine trap CSR unit
// Holds mepc, mcause, mie, global enable and MPIE
// Runs the RUN / HANDLER state machine for traps and mret
//////////////////////////////

`default_nettype none

`include "trap_defines.svh"

module trap_csr_unit
  import trap_cause_pkg::*;
  import trap_state_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_ni,
  input  wire logic        q_valid_i,
  input  wire addr_t       q_pc_i,
  input  wire cause_code_t q_code_i,
  input  wire irq_mask_t   irq_i,
  input  wire logic        mie_we_i,
  input  wire irq_mask_t   mie_wdata_i,
  input  wire logic        gie_we_i,
  input  wire logic        gie_wdata_i,
  input  wire logic        mret_i,
  input  wire addr_t       resume_pc_i,
  output logic             q_pop_o,
  output logic             trap_taken_o,
  output addr_t            mepc_o,
  output mcause_t          mcause_o,
  output irq_mask_t        mie_o,
  output logic             gie_o,
  output logic             in_handler_o
);

  handler_state_e state_q;
  logic           mpie_q;
  irq_mask_t      irq_en;
  cause_code_t    irq_idx;
  mcause_t        irq_cause;
  logic           exc_take;
  logic           irq_take;

  // Only lines that are both pending and enabled in mie can trap
  assign irq_en = irq_i & mie_o;

  // Scan from the top down so the lowest enabled line is the last one written
  always_comb begin
    irq_idx = '0;
    for (int i = `TRAP_NUM_IRQ - 1; i >= 0; i--) begin
      if (irq_en[i]) begin
        irq_idx = cause_code_t'(i);
      end
    end
  end

  always_comb begin
    irq_cause                 = mcause_t'(irq_idx);
    irq_cause[MCAUSE_IRQ_BIT] = 1'b1;
  end

  // Queued exceptions always go first, interrupts wait for an empty queue
  assign exc_take = (state_q == RUN) & q_valid_i;
  assign irq_take = (state_q == RUN) & ~q_valid_i & gie_o & (|irq_en);

  assign q_pop_o      = exc_take;
  assign in_handler_o = (state_q == HANDLER);

  //////////////////////////////
  // CSR state and handler FSM
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RUN;
      mie_o        <= '0;
      gie_o        <= 1'b0;
      mpie_q       <= 1'b0;
      mepc_o       <= '0;
      mcause_o     <= '0;
      trap_taken_o <= 1'b0;
    end else begin
      trap_taken_o <= exc_take | irq_take;
      if (mie_we_i) begin
        mie_o <= mie_wdata_i;
      end
      // Software writes first, a trap or mret in the same cycle overrides them
      if (gie_we_i) begin
        gie_o <= gie_wdata_i;
      end
      if (exc_take || irq_take) begin
        mepc_o   <= exc_take ? q_pc_i : resume_pc_i;
        mcause_o <= exc_take ? mcause_t'(q_code_i) : irq_cause;
        mpie_q   <= gie_o;
        gie_o    <= 1'b0;
        state_q  <= HANDLER;
      end else if (mret_i && (state_q == HANDLER)) begin
        gie_o   <= mpie_q;
        state_q <= RUN;
      end
    end
  end

  // An interrupt trap must have had its line enabled and the global enable set
  a_irq_was_enabled : assert property (@(posedge clk) disable iff (!rst_ni)
    trap_taken_o && mcause_o[MCAUSE_IRQ_BIT] |->
      $past(gie_o) && (|($past(mie_o) & (irq_mask_t'(1) << mcause_o[4:0]))))
    else $error("trap_csr_unit: interrupt taken while masked");

endmodule

`default_nettype wire

// ==== src/trap_sva.sv ====
//////////////////////////////
// Trap unit checker
// Compares the first trap of each cause against the retire that caused it
//////////////////////////////

`default_nettype none

module trap_sva
  import trap_cause_pkg::*;
  import trap_state_pkg::*;
(
  input wire logic      clk,
  input wire logic      rst_ni,
  input wire logic      retire_valid_i,
  input wire addr_t     retire_pc_i,
  input wire logic      retire_bus_err_i,
  input wire logic      retire_illegal_i,
  input wire logic      retire_ecall_i,
  input wire logic      retire_ebreak_i,
  input wire logic      retire_stall_i,
  input wire logic      trap_taken_i,
  input wire addr_t     mepc_i,
  input wire mcause_t   mcause_i,
  input wire irq_mask_t mie_i,
  input wire logic      gie_i
);

  // Causes in priority order, index 0 is the strongest
  localparam cause_code_t CAUSE_LIST [4] = '{
    CAUSE_INSTR_BUS_FAULT, CAUSE_ILLEGAL_INSN, CAUSE_ECALL_MMODE, CAUSE_BREAKPOINT
  };

  logic [3:0] sel_hit;
  logic [3:0] exp_found_q;
  logic [3:0] act_found_q;
  addr_t      exp_mepc_q [4];
  addr_t      act_mepc_q [4];

  // Each cause only counts when nothing stronger is flagged with it
  assign sel_hit[0] = retire_valid_i & retire_bus_err_i;
  assign sel_hit[1] = retire_valid_i & ~retire_bus_err_i & retire_illegal_i;
  assign sel_hit[2] = retire_valid_i & ~retire_bus_err_i & ~retire_illegal_i & retire_ecall_i;
  assign sel_hit[3] = retire_valid_i & ~retire_bus_err_i & ~retire_illegal_i &
                      ~retire_ecall_i & retire_ebreak_i;

  //////////////////////////////
  // First occurrence tracking
  //////////////////////////////
  for (genvar g = 0; g < 4; g++) begin : gen_cause
    always_ff @(posedge clk or negedge rst_ni) begin
      if (!rst_ni) begin
        exp_found_q[g] <= 1'b0;
        act_found_q[g] <= 1'b0;
        exp_mepc_q[g]  <= '0;
        act_mepc_q[g]  <= '0;
      end else begin
        if (!exp_found_q[g] && sel_hit[g]) begin
          exp_found_q[g] <= 1'b1;
          exp_mepc_q[g]  <= retire_pc_i;
        end
        // Interrupt traps share code values with exceptions, so skip them
        if (!act_found_q[g] && trap_taken_i && !mcause_i[MCAUSE_IRQ_BIT] &&
            (mcause_i[4:0] == CAUSE_LIST[g])) begin
          act_found_q[g] <= 1'b1;
          act_mepc_q[g]  <= mepc_i;
        end
      end
    end

    a_first_mepc : assert property (@(posedge clk) disable iff (!rst_ni)
      exp_found_q[g] && act_found_q[g] |-> exp_mepc_q[g] == act_mepc_q[g])
      else $error("trap_sva: mepc mismatch for cause %0d", CAUSE_LIST[g]);
  end

  // Retire has to hold back faulting instructions while the queue is full
  a_stall_obeyed : assert property (@(posedge clk) disable iff (!rst_ni)
    retire_stall_i |-> !(|sel_hit))
    else $error("trap_sva: flagged retire during stall");

  a_gie_cleared : assert property (@(posedge clk) disable iff (!rst_ni)
    trap_taken_i |-> !gie_i)
    else $error("trap_sva: global enable still set after trap");

  a_irq_cause_enabled : assert property (@(posedge clk) disable iff (!rst_ni)
    trap_taken_i && mcause_i[MCAUSE_IRQ_BIT] |->
      |(mie_i & (irq_mask_t'(1) << mcause_i[4:0])))
    else $error("trap_sva: interrupt cause not enabled in mie");

endmodule

`default_nettype wire

// ==== src/trap_top.sv ====
//////////////////////////////
// Machine trap unit top
// Selector, trap queue, CSR unit and checker
//////////////////////////////

`default_nettype none

module trap_top
  import trap_cause_pkg::*;
  import trap_state_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_ni,
  input  wire logic      retire_valid_i,
  input  wire addr_t     retire_pc_i,
  input  wire logic      retire_bus_err_i,
  input  wire logic      retire_illegal_i,
  input  wire logic      retire_ecall_i,
  input  wire logic      retire_ebreak_i,
  output logic           retire_stall_o,
  input  wire irq_mask_t irq_i,
  input  wire logic      mie_we_i,
  input  wire irq_mask_t mie_wdata_i,
  input  wire logic      gie_we_i,
  input  wire logic      gie_wdata_i,
  input  wire logic      mret_i,
  input  wire addr_t     resume_pc_i,
  output logic           trap_taken_o,
  output addr_t          mepc_o,
  output mcause_t        mcause_o,
  output irq_mask_t      mie_o,
  output logic           gie_o,
  output logic           in_handler_o
);

  logic        exc_push;
  addr_t       exc_pc;
  cause_code_t exc_code;
  logic        q_valid;
  addr_t       q_pc;
  cause_code_t q_code;
  logic        q_full;
  logic        q_pop;

  // Queue full doubles as the retire stall level
  assign retire_stall_o = q_full;

  retire_exc_sel u_retire_exc_sel (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .retire_valid_i   (retire_valid_i),
    .retire_pc_i      (retire_pc_i),
    .retire_bus_err_i (retire_bus_err_i),
    .retire_illegal_i (retire_illegal_i),
    .retire_ecall_i   (retire_ecall_i),
    .retire_ebreak_i  (retire_ebreak_i),
    .exc_push_o       (exc_push),
    .exc_pc_o         (exc_pc),
    .exc_code_o       (exc_code)
  );

  trap_queue u_trap_queue (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .push_i      (exc_push),
    .push_pc_i   (exc_pc),
    .push_code_i (exc_code),
    .pop_i       (q_pop),
    .valid_o     (q_valid),
    .head_pc_o   (q_pc),
    .head_code_o (q_code),
    .full_o      (q_full)
  );

  trap_csr_unit u_trap_csr_unit (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .q_valid_i    (q_valid),
    .q_pc_i       (q_pc),
    .q_code_i     (q_code),
    .irq_i        (irq_i),
    .mie_we_i     (mie_we_i),
    .mie_wdata_i  (mie_wdata_i),
    .gie_we_i     (gie_we_i),
    .gie_wdata_i  (gie_wdata_i),
    .mret_i       (mret_i),
    .resume_pc_i  (resume_pc_i),
    .q_pop_o      (q_pop),
    .trap_taken_o (trap_taken_o),
    .mepc_o       (mepc_o),
    .mcause_o     (mcause_o),
    .mie_o        (mie_o),
    .gie_o        (gie_o),
    .in_handler_o (in_handler_o)
  );

  // Checker watches the retire side against the committed CSR state
  trap_sva u_trap_sva (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .retire_valid_i   (retire_valid_i),
    .retire_pc_i      (retire_pc_i),
    .retire_bus_err_i (retire_bus_err_i),
    .retire_illegal_i (retire_illegal_i),
    .retire_ecall_i   (retire_ecall_i),
    .retire_ebreak_i  (retire_ebreak_i),
    .retire_stall_i   (q_full),
    .trap_taken_i     (trap_taken_o),
    .mepc_i           (mepc_o),
    .mcause_i         (mcause_o),
    .mie_i            (mie_o),
    .gie_i            (gie_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_trap_top.sv ====
//////////////////////////////
// Trap unit testbench
// Applies a table of retire, interrupt and CSR operations to the trap top
// and checks trap timing, mepc, mcause and the visible control state
//////////////////////////////

`default_nettype none

`include "trap_defines.svh"

module tb_trap_top;

  // Cause values as the architecture defines them
  localparam logic [31:0] EXC_BUS   = 32'd1;
  localparam logic [31:0] EXC_ILL   = 32'd2;
  localparam logic [31:0] EXC_BRK   = 32'd3;
  localparam logic [31:0] EXC_ECALL = 32'd11;
  localparam logic [31:0] IRQ_FLAG  = 32'h8000_0000;

  // Negedges to wait for an expected trap, and to watch for a stray one
  localparam int TRAP_WAIT  = 6;
  localparam int QUIET_WAIT = 4;
  localparam int MAX_ROWS   = 64;

  typedef enum logic [2:0] {OP_IDLE, OP_RETIRE, OP_IRQ, OP_MIE, OP_GIE, OP_MRET} op_e;

  // Flags are {bus_err, illegal, ecall, ebreak}
  // Data carries the irq lines, the mie mask or the global enable bit
  typedef struct packed {
    op_e         op;
    logic [3:0]  flags;
    logic [31:0] pc;
    logic [31:0] data;
    logic        exp_trap;
    logic        chk_lat;
    logic [31:0] exp_mepc;
    logic [31:0] exp_mcause;
    logic        exp_stall;
    logic        exp_gie;
    logic        exp_inh;
  } row_t;

  logic                     clk;
  logic                     rst_ni;
  logic                     retire_valid_i;
  logic [`TRAP_XLEN-1:0]    retire_pc_i;
  logic                     retire_bus_err_i;
  logic                     retire_illegal_i;
  logic                     retire_ecall_i;
  logic                     retire_ebreak_i;
  logic                     retire_stall_o;
  logic [`TRAP_NUM_IRQ-1:0] irq_i;
  logic                     mie_we_i;
  logic [`TRAP_NUM_IRQ-1:0] mie_wdata_i;
  logic                     gie_we_i;
  logic                     gie_wdata_i;
  logic                     mret_i;
  logic [`TRAP_XLEN-1:0]    resume_pc_i;
  logic                     trap_taken_o;
  logic [`TRAP_XLEN-1:0]    mepc_o;
  logic [`TRAP_XLEN-1:0]    mcause_o;
  logic [`TRAP_NUM_IRQ-1:0] mie_o;
  logic                     gie_o;
  logic                     in_handler_o;

  row_t        rows [MAX_ROWS];
  int          n_rows;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  logic        table_ready;
  logic [31:0] lfsr_q;

  // Enable mask the DUT should hold after the rows applied so far
  logic [`TRAP_NUM_IRQ-1:0] exp_mie;

  trap_top u_trap_top (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .retire_valid_i   (retire_valid_i),
    .retire_pc_i      (retire_pc_i),
    .retire_bus_err_i (retire_bus_err_i),
    .retire_illegal_i (retire_illegal_i),
    .retire_ecall_i   (retire_ecall_i),
    .retire_ebreak_i  (retire_ebreak_i),
    .retire_stall_o   (retire_stall_o),
    .irq_i            (irq_i),
    .mie_we_i         (mie_we_i),
    .mie_wdata_i      (mie_wdata_i),
    .gie_we_i         (gie_we_i),
    .gie_wdata_i      (gie_wdata_i),
    .mret_i           (mret_i),
    .resume_pc_i      (resume_pc_i),
    .trap_taken_o     (trap_taken_o),
    .mepc_o           (mepc_o),
    .mcause_o         (mcause_o),
    .mie_o            (mie_o),
    .gie_o            (gie_o),
    .in_handler_o     (in_handler_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Bus fault beats illegal, which beats ecall, which beats ebreak
  function automatic logic [31:0] exc_code_for(input logic [3:0] flags);
    if (flags[3]) return EXC_BUS;
    if (flags[2]) return EXC_ILL;
    if (flags[1]) return EXC_ECALL;
    return EXC_BRK;
  endfunction

  function automatic string op_name(input op_e op);
    case (op)
      OP_RETIRE: return "retire";
      OP_IRQ:    return "irq";
      OP_MIE:    return "mie write";
      OP_GIE:    return "gie write";
      OP_MRET:   return "mret";
      default:   return "idle";
    endcase
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_row(input op_e op, input logic [3:0] flags, input logic [31:0] pc,
                         input logic [31:0] data, input logic exp_trap, input logic chk_lat,
                         input logic [31:0] exp_mepc, input logic [31:0] exp_mcause,
                         input logic exp_stall, input logic exp_gie, input logic exp_inh);
    rows[n_rows] = '{op, flags, pc, data, exp_trap, chk_lat, exp_mepc, exp_mcause,
                     exp_stall, exp_gie, exp_inh};
    n_rows++;
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic build_table();
    logic [31:0] v;
    logic [31:0] pc;
    logic [3:0]  fl;
    n_rows = 0;
    // Flag priority from an idle unit, then a retire with no flags
    add_row(OP_IDLE,   4'b0000, 32'h0,    32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    add_row(OP_RETIRE, 4'b1111, 32'h1000, 32'h0, 1, 1, 32'h1000, EXC_BUS,   0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    add_row(OP_RETIRE, 4'b0111, 32'h1004, 32'h0, 1, 1, 32'h1004, EXC_ILL,   0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    add_row(OP_RETIRE, 4'b0011, 32'h1008, 32'h0, 1, 1, 32'h1008, EXC_ECALL, 0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    add_row(OP_RETIRE, 4'b0001, 32'h100c, 32'h0, 1, 1, 32'h100c, EXC_BRK,   0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    add_row(OP_RETIRE, 4'b0000, 32'h1010, 32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    // Two exceptions queue up behind a running handler and fill the queue
    add_row(OP_RETIRE, 4'b0100, 32'h2000, 32'h0, 1, 1, 32'h2000, EXC_ILL,   0, 0, 1);
    add_row(OP_RETIRE, 4'b0010, 32'h2004, 32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 1);
    add_row(OP_RETIRE, 4'b1000, 32'h2008, 32'h0, 0, 0, 32'h0,    32'h0,     1, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 1, 0, 32'h2004, EXC_ECALL, 0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 1, 0, 32'h2008, EXC_BUS,   0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0, 0, 0, 32'h0,    32'h0,     0, 0, 0);
    // Lines 2 and 4 enabled, line 0 pending but masked, so line 2 wins
    add_row(OP_MIE,    4'b0000, 32'h0,    32'h14, 0, 0, 32'h0,   32'h0,     0, 0, 0);
    add_row(OP_GIE,    4'b0000, 32'h0,    32'h1,  0, 0, 32'h0,   32'h0,     0, 1, 0);
    add_row(OP_IRQ,    4'b0000, 32'h3000, 32'h15, 1, 0, 32'h3000, IRQ_FLAG | 32'd2, 0, 0, 1);
    add_row(OP_IRQ,    4'b0000, 32'h3000, 32'h0,  0, 0, 32'h0,   32'h0,     0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0,  0, 0, 32'h0,   32'h0,     0, 1, 0);
    // Line 3 waits for its mie bit
    add_row(OP_IRQ,    4'b0000, 32'h3100, 32'h8,  0, 0, 32'h0,   32'h0,     0, 1, 0);
    add_row(OP_MIE,    4'b0000, 32'h0,    32'h1c, 1, 0, 32'h3100, IRQ_FLAG | 32'd3, 0, 0, 1);
    add_row(OP_IRQ,    4'b0000, 32'h3100, 32'h0,  0, 0, 32'h0,   32'h0,     0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0,  0, 0, 32'h0,   32'h0,     0, 1, 0);
    // Line 4 waits for the global enable
    add_row(OP_GIE,    4'b0000, 32'h0,    32'h0,  0, 0, 32'h0,   32'h0,     0, 0, 0);
    add_row(OP_IRQ,    4'b0000, 32'h3200, 32'h10, 0, 0, 32'h0,   32'h0,     0, 0, 0);
    add_row(OP_GIE,    4'b0000, 32'h0,    32'h1,  1, 0, 32'h3200, IRQ_FLAG | 32'd4, 0, 0, 1);
    add_row(OP_IRQ,    4'b0000, 32'h3200, 32'h0,  0, 0, 32'h0,   32'h0,     0, 0, 1);
    add_row(OP_MRET,   4'b0000, 32'h0,    32'h0,  0, 0, 32'h0,   32'h0,     0, 1, 0);
    // Random word aligned PCs and flags, each retire followed by an mret
    for (int i = 0; i < 6; i++) begin
      rand_bits(30, v);
      pc = {v[29:0], 2'b00};
      rand_bits(4, v);
      fl = v[3:0];
      if (fl != 4'b0000) begin
        add_row(OP_RETIRE, fl, pc, 32'h0, 1, 1, pc, exc_code_for(fl), 0, 0, 1);
      end else begin
        add_row(OP_RETIRE, fl, pc, 32'h0, 0, 0, 32'h0, 32'h0, 0, 1, 0);
      end
      add_row(OP_MRET, 4'b0000, 32'h0, 32'h0, 0, 0, 32'h0, 32'h0, 0, 1, 0);
    end
  endtask

  //////////////////////////////
  // Row execution
  //////////////////////////////
  task automatic run_row(input int idx);
    row_t r;
    int   cyc;
    int   lat;
    int   errs_before;
    logic seen;
    r           = rows[idx];
    errs_before = err_cnt;
    @(posedge clk);
    case (r.op)
      OP_RETIRE: begin
        retire_valid_i <= 1'b1;
        retire_pc_i    <= r.pc;
        {retire_bus_err_i, retire_illegal_i, retire_ecall_i, retire_ebreak_i} <= r.flags;
      end
      OP_IRQ: begin
        irq_i       <= r.data[`TRAP_NUM_IRQ-1:0];
        resume_pc_i <= r.pc;
      end
      OP_MIE: begin
        mie_we_i    <= 1'b1;
        mie_wdata_i <= r.data[`TRAP_NUM_IRQ-1:0];
        exp_mie     = r.data[`TRAP_NUM_IRQ-1:0];
      end
      OP_GIE: begin
        gie_we_i    <= 1'b1;
        gie_wdata_i <= r.data[0];
      end
      OP_MRET: mret_i <= 1'b1;
      default: ;
    endcase
    // The DUT samples the row at this edge, strobes drop right after
    @(posedge clk);
    retire_valid_i <= 1'b0;
    {retire_bus_err_i, retire_illegal_i, retire_ecall_i, retire_ebreak_i} <= 4'b0000;
    mie_we_i <= 1'b0;
    gie_we_i <= 1'b0;
    mret_i   <= 1'b0;
    seen = 1'b0;
    lat  = -1;
    cyc  = 0;
    // Outputs are looked at on the falling edge, away from the drive edge
    while (!seen && cyc < (r.exp_trap ? TRAP_WAIT : QUIET_WAIT)) begin
      @(negedge clk);
      cyc++;
      if (trap_taken_o) begin
        seen = 1'b1;
        lat  = cyc - 1;
      end
    end
    check_val("trap taken", seen, r.exp_trap);
    if (seen && r.exp_trap) begin
      check_val("mepc", mepc_o, r.exp_mepc);
      check_val("mcause", mcause_o, r.exp_mcause);
      // Latency counts clock edges from the edge that sampled the retire
      if (r.chk_lat) check_val("trap latency", lat, 32'd2);
    end
    check_val("retire stall", retire_stall_o, r.exp_stall);
    check_val("global enable", gie_o, r.exp_gie);
    check_val("in handler", in_handler_o, r.exp_inh);
    check_val("mie", mie_o, exp_mie);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("Row %0d (%s): ok", idx, op_name(r.op));
    end else begin
      fail_cnt++;
      $display("Row %0d (%s): FAILED", idx, op_name(r.op));
    end
  endtask

  // Watchdog that bounds the whole run by the table length
  initial begin
    cycle_cnt = 0;
    wait (table_ready);
    cycle_limit = 10 * n_rows;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failures found");
    $finish;
  end

  initial begin
    rst_ni           = 1'b0;
    retire_valid_i   = 1'b0;
    retire_pc_i      = '0;
    retire_bus_err_i = 1'b0;
    retire_illegal_i = 1'b0;
    retire_ecall_i   = 1'b0;
    retire_ebreak_i  = 1'b0;
    irq_i            = '0;
    mie_we_i         = 1'b0;
    mie_wdata_i      = '0;
    gie_we_i         = 1'b0;
    gie_wdata_i      = 1'b0;
    mret_i           = 1'b0;
    resume_pc_i      = '0;
    err_cnt          = 0;
    pass_cnt         = 0;
    fail_cnt         = 0;
    exp_mie          = '0;
    table_ready      = 1'b0;
    lfsr_q           = 32'ha51d26d5;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    rst_ni <= 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("Summary: %0d rows, %0d passed, %0d failed, %0d check errors",
             n_rows, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/trap_cause_pkg.sv
src/trap_state_pkg.sv
src/retire_exc_sel.sv
src/trap_queue.sv
src/trap_csr_unit.sv
src/trap_sva.sv
src/trap_top.sv
dv/tb_trap_top.sv

// ==== Bender.yml ====
package:
  name: trap_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/trap_cause_pkg.sv
      - src/trap_state_pkg.sv
      - src/retire_exc_sel.sv
      - src/trap_queue.sv
      - src/trap_csr_unit.sv
      - src/trap_sva.sv
      - src/trap_top.sv

  - target: simulation
    include_dirs:
      - src
    files:
      - dv/tb_trap_top.sv
